// File: Bender.yml
package:
  name: regf_top

sources:
  - include_dirs:
      - design
    files:
      - design/regf_pkg.sv
      - design/regf_dec_if.sv
      - design/regf_arch_regs.sv
      - design/regf_osreq_counter.sv
      - design/regf_load_scoreboard.sv
      - design/regf_mem_req.sv
      - design/regf_top.sv
  - target: test
    files:
      - test/regf_checker.sv
      - test/regf_tb.sv

// File: design/regf_arch_regs.sv
//**************************************************************************
// architectural register files
// integer and fp arrays, write arbitration, operand read and the
// registered outputs towards the issue queue
//**************************************************************************
`timescale 1ns/1ps
`include "regf_consts.svh"

module regf_arch_regs (
  input  logic                sclk,
  input  logic                rstn,
  regf_dec_if.sink            dec,
  input  logic                rob_wr_en,
  input  regf_pkg::rob_addr_t rob_wr_addr,
  input  regf_pkg::xlen_t     rob_wr_data,
  input  logic                rsp_fire,
  input  regf_pkg::reg_idx_t  rsp_cid,
  input  regf_pkg::xlen_t     rsp_data,
  output regf_pkg::xlen_t     regval_rs1,
  output regf_pkg::xlen_t     regval_rs2,
  output regf_pkg::reg_idx_t  isq_rd,
  output regf_pkg::func_op_t  isq_func,
  output regf_pkg::xlen_t     isq_immd,
  output regf_pkg::xlen_t     rs1_val,
  output regf_pkg::xlen_t     rs2_val
);

  regf_pkg::xlen_t    int_regs [`REGF_NUM_REGS];
  regf_pkg::xlen_t    fp_regs  [`REGF_NUM_REGS];
  logic               rsp_we;
  logic               jal_we;
  logic               immd_we;
  logic               rob_int_we;
  logic               rob_fp_we;
  logic               int_we;
  regf_pkg::reg_idx_t int_wr_idx;
  regf_pkg::xlen_t    int_wr_data;
  logic               fpu_sel;

  // x0 is never a write target, so each source drops it on its own
  assign rsp_we     = rsp_fire && (rsp_cid != '0);
  assign jal_we     = (dec.main == regf_pkg::MAIN_PREDICT) && (dec.func == regf_pkg::JAL) &&
                      (dec.rd != '0);
  assign immd_we    = (dec.main == regf_pkg::MAIN_MEMORY) && (dec.func == regf_pkg::LD_IMMD) &&
                      (dec.rd != '0);
  assign rob_int_we = rob_wr_en && !rob_wr_addr.is_fp && (rob_wr_addr.idx != '0);
  assign rob_fp_we  = rob_wr_en && rob_wr_addr.is_fp;  // f0 is a normal register
  assign int_we     = rsp_we || jal_we || immd_we || rob_int_we;

  always_comb begin
    int_wr_idx  = rob_wr_addr.idx;
    int_wr_data = rob_wr_data;
    if (rsp_we) begin
      int_wr_idx  = rsp_cid;  // load data first
      int_wr_data = rsp_data;
    end else if (jal_we) begin
      int_wr_idx  = dec.rd;
      int_wr_data = dec.pc + regf_pkg::xlen_t'(4);  // link address
    end else if (immd_we) begin
      int_wr_idx  = dec.rd;
      int_wr_data = dec.immd;
    end
  end

  always_ff @(posedge sclk or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < `REGF_NUM_REGS; i++) begin
        int_regs[i] <= '0;
        fp_regs[i]  <= '0;
      end
    end else begin
      if (int_we) begin
        int_regs[int_wr_idx] <= int_wr_data;
      end
      if (rob_fp_we) begin
        fp_regs[rob_wr_addr.idx] <= rob_wr_data;
      end
    end
  end

  assign fpu_sel = (dec.main == regf_pkg::MAIN_FPU);
  assign rs1_val = fpu_sel ? fp_regs[dec.rs1] : int_regs[dec.rs1];  // x0 keeps its reset zero
  assign rs2_val = fpu_sel ? fp_regs[dec.rs2] : int_regs[dec.rs2];

  always_ff @(posedge sclk or negedge rstn) begin
    if (!rstn) begin
      regval_rs1 <= '0;
      regval_rs2 <= '0;
      isq_rd     <= '0;
      isq_func   <= regf_pkg::func_op_t'({`REGF_OP_W{1'b0}});
      isq_immd   <= '0;
    end else begin
      regval_rs1 <= rs1_val;  // no bypass of this cycle's write
      regval_rs2 <= rs2_val;
      isq_rd     <= dec.rd;
      isq_func   <= dec.func;
      isq_immd   <= dec.immd;
    end
  end

endmodule

// File: design/regf_consts.svh
//**************************************************************************
// register file stage constants
// widths, register count, outstanding limit and opcode encodings
//**************************************************************************
`ifndef REGF_CONSTS_SVH
`define REGF_CONSTS_SVH

`define REGF_XLEN       32
`define REGF_IDX_W      5
`define REGF_NUM_REGS   32
`define REGF_MAX_OSREQ  4   // requests in flight
`define REGF_OSREQ_W    3
`define REGF_OP_W       8

`define REGF_MAIN_NONE     8'd0  // bubble
`define REGF_MAIN_ADDER    8'd1
`define REGF_MAIN_MULDIV   8'd2
`define REGF_MAIN_LOGIC    8'd3
`define REGF_MAIN_FPU      8'd4
`define REGF_MAIN_MEMORY   8'd5
`define REGF_MAIN_PREDICT  8'd6

`define REGF_LD_BYTE            8'd1
`define REGF_LD_HWORD           8'd2
`define REGF_LD_WORD            8'd3
`define REGF_LD_BYTE_UNSIGNED   8'd4
`define REGF_LD_HWORD_UNSIGNED  8'd5
`define REGF_LD_WORD_UNSIGNED   8'd6
`define REGF_LD_IMMD            8'd7
`define REGF_ST_BYTE            8'd8
`define REGF_ST_HWORD           8'd9
`define REGF_ST_WORD            8'd10
`define REGF_JAL                8'd11
`define REGF_AUIPC              8'd12

`endif

// File: design/regf_dec_if.sv
//**************************************************************************
// decoded instruction bundle
// carries one decoded instruction from the top into the stage blocks
//**************************************************************************
`timescale 1ns/1ps

interface regf_dec_if;

  regf_pkg::main_op_t main;
  regf_pkg::func_op_t func;
  regf_pkg::reg_idx_t rs1;
  regf_pkg::reg_idx_t rs2;
  regf_pkg::reg_idx_t rd;
  regf_pkg::xlen_t    immd;
  regf_pkg::xlen_t    pc;    // pc of the decoded instruction

  modport src (
    output main, func, rs1, rs2, rd, immd, pc
  );

  modport sink (
    input main, func, rs1, rs2, rd, immd, pc
  );

endinterface

// File: design/regf_load_scoreboard.sv
//**************************************************************************
// load scoreboard
// one pending bit per integer register waiting for load data, plus the
// hazard check on the instruction at decode
//**************************************************************************
`timescale 1ns/1ps
`include "regf_consts.svh"

module regf_load_scoreboard (
  input  logic               sclk,
  input  logic               rstn,
  regf_dec_if.sink           dec,
  input  logic               load_fire,
  input  logic               rsp_fire,
  input  regf_pkg::reg_idx_t rsp_cid,
  output logic               hazard
);

  logic [`REGF_NUM_REGS-1:0] pending;
  logic                      bubble;
  logic                      src_busy;
  logic                      rd_busy;

  always_ff @(posedge sclk or negedge rstn) begin
    if (!rstn) begin
      pending <= '0;
    end else begin
      if (rsp_fire) begin
        pending[rsp_cid] <= 1'b0;
      end
      // a load never targets a pending rd, so no clash with the clear
      if (load_fire && (dec.rd != '0)) begin
        pending[dec.rd] <= 1'b1;
      end
    end
  end

  assign bubble   = (dec.main == regf_pkg::MAIN_NONE);
  assign src_busy = pending[dec.rs1] || pending[dec.rs2];
  assign rd_busy  = regf_pkg::is_load(dec.main, dec.func) && pending[dec.rd];  // load after load
  assign hazard   = (!bubble && src_busy) || rd_busy;

endmodule

// File: design/regf_mem_req.sv
//**************************************************************************
// memory request builder
// turns load and store instructions into registered requests, at most
// four outstanding
//**************************************************************************
`timescale 1ns/1ps

module regf_mem_req (
  input  logic                 sclk,
  input  logic                 rstn,
  regf_dec_if.sink             dec,
  input  regf_pkg::xlen_t      rs1_val,
  input  regf_pkg::xlen_t      rs2_val,
  input  logic                 req_ready,
  input  logic                 hazard,
  input  logic                 rsp_fire,
  output logic                 req_valid,
  output regf_pkg::xlen_t      req_addr,
  output regf_pkg::xlen_t      req_data,
  output regf_pkg::mem_kind_t  req_kind,
  output regf_pkg::byte_mask_t req_mask,
  output regf_pkg::reg_idx_t   req_cid,
  output logic                 mem_block,
  output logic                 load_fire
);

  logic                 is_ld;
  logic                 is_st;
  logic                 is_mem;
  logic                 send;
  logic                 osreq_full;
  regf_pkg::byte_mask_t mask_nxt;

  assign is_ld     = regf_pkg::is_load(dec.main, dec.func);
  assign is_st     = regf_pkg::is_store(dec.main, dec.func);
  assign is_mem    = is_ld || is_st;
  assign mem_block = is_mem && (!req_ready || osreq_full);
  assign send      = is_mem && !mem_block && !hazard;
  assign load_fire = send && is_ld;  // marks rd pending

  regf_osreq_counter u_osreq (
    .sclk (sclk),
    .rstn (rstn),
    .inc  (send),
    .dec  (rsp_fire),  // one response per request
    .full (osreq_full)
  );

  always_comb begin
    case (dec.func)
      regf_pkg::LD_BYTE, regf_pkg::LD_BYTE_UNSIGNED, regf_pkg::ST_BYTE: begin
        mask_nxt = 4'b0001;
      end
      regf_pkg::LD_HWORD, regf_pkg::LD_HWORD_UNSIGNED, regf_pkg::ST_HWORD: begin
        mask_nxt = 4'b0011;
      end
      default: begin
        mask_nxt = 4'b1111;
      end
    endcase
  end

  always_ff @(posedge sclk or negedge rstn) begin
    if (!rstn) begin
      req_valid <= 1'b0;
      req_addr  <= '0;
      req_data  <= '0;
      req_kind  <= regf_pkg::MEM_NONE;
      req_mask  <= '0;
      req_cid   <= '0;
    end else begin
      req_valid <= send;  // single cycle pulse
      if (send) begin
        req_addr <= rs1_val + dec.immd;
        req_data <= is_st ? rs2_val : '0;
        req_kind <= is_ld ? regf_pkg::MEM_READ : regf_pkg::MEM_WRITE;
        req_mask <= mask_nxt;
        req_cid  <= is_ld ? dec.rd : '0;  // stores answer on x0
      end
    end
  end

endmodule

// File: design/regf_osreq_counter.sv
//**************************************************************************
// outstanding request counter
// tracks memory requests in flight and flags the limit
//**************************************************************************
`timescale 1ns/1ps
`include "regf_consts.svh"

module regf_osreq_counter (
  input  logic sclk,
  input  logic rstn,
  input  logic inc,
  input  logic dec,
  output logic full
);

  logic [`REGF_OSREQ_W-1:0] count;

  always_ff @(posedge sclk or negedge rstn) begin
    if (!rstn) begin
      count <= '0;
    end else if (inc && !dec) begin
      count <= count + 1'b1;
    end else if (dec && !inc) begin
      count <= count - 1'b1;
    end
    // inc with dec holds the count
  end

  assign full = (count == `REGF_OSREQ_W'(`REGF_MAX_OSREQ));

endmodule

// File: design/regf_pkg.sv
//**************************************************************************
// register file stage types
// register words, indices, opcodes and memory request kinds
//**************************************************************************
`include "regf_consts.svh"

package regf_pkg;

  typedef logic [`REGF_XLEN-1:0]  xlen_t;
  typedef logic [`REGF_IDX_W-1:0] reg_idx_t;

  typedef struct packed {
    logic     is_fp;  // 1 selects the fp file
    reg_idx_t idx;
  } rob_addr_t;

  typedef enum logic [`REGF_OP_W-1:0] {
    MAIN_NONE    = `REGF_MAIN_NONE,
    MAIN_ADDER   = `REGF_MAIN_ADDER,
    MAIN_MULDIV  = `REGF_MAIN_MULDIV,
    MAIN_LOGIC   = `REGF_MAIN_LOGIC,
    MAIN_FPU     = `REGF_MAIN_FPU,
    MAIN_MEMORY  = `REGF_MAIN_MEMORY,
    MAIN_PREDICT = `REGF_MAIN_PREDICT
  } main_op_t;

  typedef enum logic [`REGF_OP_W-1:0] {
    LD_BYTE            = `REGF_LD_BYTE,
    LD_HWORD           = `REGF_LD_HWORD,
    LD_WORD            = `REGF_LD_WORD,
    LD_BYTE_UNSIGNED   = `REGF_LD_BYTE_UNSIGNED,
    LD_HWORD_UNSIGNED  = `REGF_LD_HWORD_UNSIGNED,
    LD_WORD_UNSIGNED   = `REGF_LD_WORD_UNSIGNED,
    LD_IMMD            = `REGF_LD_IMMD,
    ST_BYTE            = `REGF_ST_BYTE,
    ST_HWORD           = `REGF_ST_HWORD,
    ST_WORD            = `REGF_ST_WORD,
    JAL                = `REGF_JAL,
    AUIPC              = `REGF_AUIPC
  } func_op_t;

  typedef enum logic [1:0] {
    MEM_NONE  = 2'd0,
    MEM_WRITE = 2'd1,
    MEM_READ  = 2'd2
  } mem_kind_t;

  typedef logic [3:0] byte_mask_t;

  // loads that go out to memory, load immediate excluded
  function automatic logic is_load(main_op_t main, func_op_t func);
    return (main == MAIN_MEMORY) &&
           (func inside {LD_BYTE, LD_HWORD, LD_WORD,
                         LD_BYTE_UNSIGNED, LD_HWORD_UNSIGNED, LD_WORD_UNSIGNED});
  endfunction

  function automatic logic is_store(main_op_t main, func_op_t func);
    return (main == MAIN_MEMORY) && (func inside {ST_BYTE, ST_HWORD, ST_WORD});
  endfunction

endpackage

// File: design/regf_top.sv
//**************************************************************************
// register file operand stage
// reads operands for the issue queue, sends loads and stores to memory
// and stalls fetch on load hazards or memory back-pressure
//**************************************************************************
`timescale 1ns/1ps

module regf_top (
  input  logic                 sclk,
  input  logic                 rstn,
  input  regf_pkg::xlen_t      pc,
  input  regf_pkg::main_op_t   dec_main,
  input  regf_pkg::func_op_t   dec_func,
  input  regf_pkg::reg_idx_t   dec_rs1,
  input  regf_pkg::reg_idx_t   dec_rs2,
  input  regf_pkg::reg_idx_t   dec_rd,
  input  regf_pkg::xlen_t      dec_immd,
  output regf_pkg::xlen_t      regval_rs1,
  output regf_pkg::xlen_t      regval_rs2,
  output regf_pkg::reg_idx_t   isq_rd,
  output regf_pkg::func_op_t   isq_func,
  output regf_pkg::xlen_t      isq_immd,
  output logic                 jmp_en,
  output logic                 stall,
  input  logic                 req_ready,
  output regf_pkg::xlen_t      req_addr,
  output regf_pkg::xlen_t      req_data,
  output regf_pkg::mem_kind_t  req_kind,
  output logic                 req_valid,
  output regf_pkg::byte_mask_t req_mask,
  output regf_pkg::reg_idx_t   req_cid,
  input  regf_pkg::reg_idx_t   rsp_cid,
  input  regf_pkg::xlen_t      rsp_data,
  input  logic                 rsp_vld,
  output logic                 rsp_ready,
  input  logic                 rob_wr_en,
  input  regf_pkg::rob_addr_t  rob_wr_addr,
  input  regf_pkg::xlen_t      rob_wr_data
);

  regf_dec_if      dec_bus ();
  regf_pkg::xlen_t rs1_val;
  regf_pkg::xlen_t rs2_val;
  logic            rsp_fire;
  logic            hazard;
  logic            mem_block;
  logic            load_fire;
  logic            is_jump;

  assign dec_bus.main = dec_main;
  assign dec_bus.func = dec_func;
  assign dec_bus.rs1  = dec_rs1;
  assign dec_bus.rs2  = dec_rs2;
  assign dec_bus.rd   = dec_rd;
  assign dec_bus.immd = dec_immd;
  assign dec_bus.pc   = pc;

  assign rsp_ready = 1'b1;  // responses never back-pressured
  assign rsp_fire  = rsp_vld && rsp_ready;
  assign stall     = hazard || mem_block;

  assign is_jump = ((dec_main == regf_pkg::MAIN_PREDICT) && (dec_func == regf_pkg::JAL)) ||
                   ((dec_main == regf_pkg::MAIN_ADDER) && (dec_func == regf_pkg::AUIPC));

  always_ff @(posedge sclk or negedge rstn) begin
    if (!rstn) begin
      jmp_en <= 1'b0;
    end else begin
      jmp_en <= is_jump;
    end
  end

  regf_arch_regs u_arch_regs (
    .sclk        (sclk),
    .rstn        (rstn),
    .dec         (dec_bus.sink),
    .rob_wr_en   (rob_wr_en),
    .rob_wr_addr (rob_wr_addr),
    .rob_wr_data (rob_wr_data),
    .rsp_fire    (rsp_fire),
    .rsp_cid     (rsp_cid),
    .rsp_data    (rsp_data),
    .regval_rs1  (regval_rs1),
    .regval_rs2  (regval_rs2),
    .isq_rd      (isq_rd),
    .isq_func    (isq_func),
    .isq_immd    (isq_immd),
    .rs1_val     (rs1_val),
    .rs2_val     (rs2_val)
  );

  regf_mem_req u_mem_req (
    .sclk      (sclk),
    .rstn      (rstn),
    .dec       (dec_bus.sink),
    .rs1_val   (rs1_val),
    .rs2_val   (rs2_val),
    .req_ready (req_ready),
    .hazard    (hazard),
    .rsp_fire  (rsp_fire),
    .req_valid (req_valid),
    .req_addr  (req_addr),
    .req_data  (req_data),
    .req_kind  (req_kind),
    .req_mask  (req_mask),
    .req_cid   (req_cid),
    .mem_block (mem_block),
    .load_fire (load_fire)
  );

  regf_load_scoreboard u_scoreboard (
    .sclk      (sclk),
    .rstn      (rstn),
    .dec       (dec_bus.sink),
    .load_fire (load_fire),
    .rsp_fire  (rsp_fire),
    .rsp_cid   (rsp_cid),
    .hazard    (hazard)
  );

endmodule

// File: regf_top.f
+incdir+design
design/regf_pkg.sv
design/regf_dec_if.sv
design/regf_arch_regs.sv
design/regf_osreq_counter.sv
design/regf_load_scoreboard.sv
design/regf_mem_req.sv
design/regf_top.sv
test/regf_checker.sv
test/regf_tb.sv

// File: test/regf_checker.sv
//**************************************************************************
// register file stage protocol checker
// assertions on the top-level ports, bound into regf_top
//**************************************************************************
`timescale 1ns/1ps

module regf_checker (
  input logic                sclk,
  input logic                rstn,
  input regf_pkg::main_op_t  dec_main,
  input regf_pkg::func_op_t  dec_func,
  input logic                stall,
  input logic                jmp_en,
  input logic                req_valid,
  input regf_pkg::mem_kind_t req_kind,
  input logic                rsp_ready,
  input regf_pkg::xlen_t     regval_rs1,
  input regf_pkg::xlen_t     regval_rs2
);

  int   fail_count = 0;  // read by the testbench at the end
  logic jump_dec;
  logic mem_sent;
  logic outs_low;

  assign jump_dec = ((dec_main == regf_pkg::MAIN_PREDICT) && (dec_func == regf_pkg::JAL)) ||
                    ((dec_main == regf_pkg::MAIN_ADDER) && (dec_func == regf_pkg::AUIPC));
  assign mem_sent = (dec_main == regf_pkg::MAIN_MEMORY) && !stall;
  assign outs_low = !req_valid && !jmp_en && (regval_rs1 == '0) && (regval_rs2 == '0) &&
                    ((dec_main != regf_pkg::MAIN_NONE) || !stall);

  req_follows_send: assert property (@(posedge sclk) disable iff (!rstn)
    req_valid |-> ($past(mem_sent) &&
                   (req_kind == regf_pkg::MEM_READ || req_kind == regf_pkg::MEM_WRITE)))
  else begin
    fail_count++;
    $error("request valid without a sent memory instruction, or with a bad kind");
  end

  jmp_single: assert property (@(posedge sclk) disable iff (!rstn)
    (jmp_en && $past(jmp_en)) |-> $past(jump_dec))  // back to back only for two jumps
  else begin
    fail_count++;
    $error("jump strobe stayed high without a second jump");
  end

  rsp_always_ready: assert property (@(posedge sclk) rsp_ready)
  else begin
    fail_count++;
    $error("response ready went low");
  end

  quiet_in_reset: assert property (@(posedge sclk) !rstn |-> outs_low)
  else begin
    fail_count++;
    $error("outputs not low while reset is asserted");
  end

endmodule

// File: test/regf_tb.sv
//**************************************************************************
// register file stage testbench
// table of decode, retire and response stimulus with expected outputs,
// applied row by row against regf_top
//**************************************************************************
`timescale 1ns/1ps

module regf_tb;

  typedef struct {
    logic [7:0]           main;
    logic [7:0]           func;
    regf_pkg::reg_idx_t   rs1;
    regf_pkg::reg_idx_t   rs2;
    regf_pkg::reg_idx_t   rd;
    regf_pkg::xlen_t      immd;
    regf_pkg::xlen_t      pc;
    logic                 rob_en;
    regf_pkg::rob_addr_t  rob_addr;
    regf_pkg::xlen_t      rob_data;
    logic                 rsp_vld;
    regf_pkg::reg_idx_t   rsp_cid;
    regf_pkg::xlen_t      rsp_data;
    logic                 ready;
    logic                 e_stall;  // combinational, same cycle
    logic                 e_jmp;    // the rest one cycle later
    logic                 e_rs_chk;
    regf_pkg::xlen_t      e_rs1;
    regf_pkg::xlen_t      e_rs2;
    logic                 e_req;
    logic [1:0]           e_kind;
    regf_pkg::byte_mask_t e_mask;
    regf_pkg::xlen_t      e_addr;
    regf_pkg::xlen_t      e_data;
    regf_pkg::reg_idx_t   e_cid;
  } row_t;

  logic                 sclk = 1'b0;
  logic                 rstn;
  regf_pkg::xlen_t      pc;
  regf_pkg::main_op_t   dec_main;
  regf_pkg::func_op_t   dec_func;
  regf_pkg::reg_idx_t   dec_rs1;
  regf_pkg::reg_idx_t   dec_rs2;
  regf_pkg::reg_idx_t   dec_rd;
  regf_pkg::xlen_t      dec_immd;
  regf_pkg::xlen_t      regval_rs1;
  regf_pkg::xlen_t      regval_rs2;
  regf_pkg::reg_idx_t   isq_rd;
  regf_pkg::func_op_t   isq_func;
  regf_pkg::xlen_t      isq_immd;
  logic                 jmp_en;
  logic                 stall;
  logic                 req_ready;
  regf_pkg::xlen_t      req_addr;
  regf_pkg::xlen_t      req_data;
  regf_pkg::mem_kind_t  req_kind;
  logic                 req_valid;
  regf_pkg::byte_mask_t req_mask;
  regf_pkg::reg_idx_t   req_cid;
  regf_pkg::reg_idx_t   rsp_cid;
  regf_pkg::xlen_t      rsp_data;
  logic                 rsp_vld;
  logic                 rsp_ready;
  logic                 rob_wr_en;
  regf_pkg::rob_addr_t  rob_wr_addr;
  regf_pkg::xlen_t      rob_wr_data;

  row_t tbl [64];
  int   n_rows = 0;
  int   n_checks = 0;
  int   n_errors = 0;
  logic table_built = 1'b0;

  always #2 sclk = ~sclk;  // 4 ns period

  regf_top dut_i (.*);

  bind regf_top regf_checker chk_i (
    .sclk       (sclk),
    .rstn       (rstn),
    .dec_main   (dec_main),
    .dec_func   (dec_func),
    .stall      (stall),
    .jmp_en     (jmp_en),
    .req_valid  (req_valid),
    .req_kind   (req_kind),
    .rsp_ready  (rsp_ready),
    .regval_rs1 (regval_rs1),
    .regval_rs2 (regval_rs2)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic row_t blank();
    row_t r;
    r       = '{default: '0};  // bubble, no writes
    r.ready = 1'b1;
    return r;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Fail at time %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic push_op(input logic [7:0] m, input logic [7:0] f, input regf_pkg::reg_idx_t s1,
                         input regf_pkg::reg_idx_t s2, input regf_pkg::reg_idx_t d,
                         input regf_pkg::xlen_t im);
    row_t r;
    r      = blank();
    r.main = m;
    r.func = f;
    r.rs1  = s1;
    r.rs2  = s2;
    r.rd   = d;
    r.immd = im;
    r.pc   = 32'h0000_1000 + 32'(n_rows * 4);
    tbl[n_rows] = r;
    n_rows++;
  endtask

  // decoder holds the previous instruction
  task automatic repeat_op();
    row_t r;
    r          = tbl[n_rows-1];
    r.rob_en   = 1'b0;
    r.rsp_vld  = 1'b0;
    r.ready    = 1'b1;
    r.e_stall  = 1'b0;
    r.e_jmp    = 1'b0;
    r.e_rs_chk = 1'b0;
    r.e_req    = 1'b0;
    tbl[n_rows] = r;
    n_rows++;
  endtask

  task automatic retire(input logic fp, input regf_pkg::reg_idx_t idx, input regf_pkg::xlen_t v);
    tbl[n_rows-1].rob_en   = 1'b1;
    tbl[n_rows-1].rob_addr = {fp, idx};
    tbl[n_rows-1].rob_data = v;
  endtask

  task automatic respond(input regf_pkg::reg_idx_t cid, input regf_pkg::xlen_t v);
    tbl[n_rows-1].rsp_vld  = 1'b1;
    tbl[n_rows-1].rsp_cid  = cid;
    tbl[n_rows-1].rsp_data = v;
  endtask

  task automatic want_operands(input regf_pkg::xlen_t a, input regf_pkg::xlen_t b);
    tbl[n_rows-1].e_rs_chk = 1'b1;
    tbl[n_rows-1].e_rs1    = a;
    tbl[n_rows-1].e_rs2    = b;
  endtask

  task automatic want_request(input logic [1:0] kind, input regf_pkg::byte_mask_t mask,
                              input regf_pkg::xlen_t addr, input regf_pkg::xlen_t data,
                              input regf_pkg::reg_idx_t cid);
    tbl[n_rows-1].e_req  = 1'b1;
    tbl[n_rows-1].e_kind = kind;
    tbl[n_rows-1].e_mask = mask;
    tbl[n_rows-1].e_addr = addr;
    tbl[n_rows-1].e_data = data;
    tbl[n_rows-1].e_cid  = cid;
  endtask

  task automatic build_table();
    regf_pkg::xlen_t d [13];
    regf_pkg::xlen_t link;
    logic [31:0]     rng;
    rng = 32'hf342_850d;
    for (int i = 0; i < 13; i++) begin
      rng  = xorshift(rng);
      d[i] = rng;
    end
    // retire into both files, x0 stays zero, FPU opcode picks the fp file
    push_op(regf_pkg::MAIN_ADDER, regf_pkg::LD_WORD, 5'd0, 5'd0, 5'd0, 32'h0);
    retire(1'b0, 5'd3, d[0]);
    push_op(regf_pkg::MAIN_ADDER, regf_pkg::LD_WORD, 5'd3, 5'd0, 5'd0, 32'h0);
    retire(1'b1, 5'd3, d[1]);
    want_operands(d[0], 32'h0);
    push_op(regf_pkg::MAIN_FPU, regf_pkg::LD_WORD, 5'd3, 5'd0, 5'd0, 32'h0);
    retire(1'b0, 5'd0, d[2]);
    want_operands(d[1], 32'h0);
    push_op(regf_pkg::MAIN_ADDER, regf_pkg::LD_WORD, 5'd0, 5'd3, 5'd0, 32'h0);
    retire(1'b1, 5'd0, d[3]);
    want_operands(32'h0, d[0]);
    push_op(regf_pkg::MAIN_FPU, regf_pkg::LD_WORD, 5'd0, 5'd3, 5'd0, 32'h0);
    want_operands(d[3], d[1]);
    // load immediate, jal link and the jump strobe
    push_op(regf_pkg::MAIN_MEMORY, regf_pkg::LD_IMMD, 5'd0, 5'd0, 5'd7, d[4]);
    push_op(regf_pkg::MAIN_PREDICT, regf_pkg::JAL, 5'd7, 5'd0, 5'd8, 32'h0);
    want_operands(d[4], 32'h0);
    tbl[n_rows-1].e_jmp = 1'b1;
    link = tbl[n_rows-1].pc + 32'd4;
    push_op(regf_pkg::MAIN_ADDER, regf_pkg::AUIPC, 5'd8, 5'd7, 5'd0, 32'h0);
    want_operands(link, d[4]);
    tbl[n_rows-1].e_jmp = 1'b1;
    push_op(regf_pkg::MAIN_LOGIC, regf_pkg::LD_WORD, 5'd0, 5'd0, 5'd0, 32'h0);
    // every load and store width, each answered on the next row
    push_op(regf_pkg::MAIN_MEMORY, regf_pkg::LD_BYTE, 5'd3, 5'd0, 5'd10, 32'h10);
    want_request(regf_pkg::MEM_READ, 4'b0001, d[0] + 32'h10, 32'h0, 5'd10);
    push_op(regf_pkg::MAIN_MEMORY, regf_pkg::LD_HWORD_UNSIGNED, 5'd3, 5'd0, 5'd11, 32'h20);
    respond(5'd10, d[5]);
    want_request(regf_pkg::MEM_READ, 4'b0011, d[0] + 32'h20, 32'h0, 5'd11);
    push_op(regf_pkg::MAIN_MEMORY, regf_pkg::LD_WORD, 5'd3, 5'd0, 5'd12, 32'h4);
    respond(5'd11, d[6]);
    want_request(regf_pkg::MEM_READ, 4'b1111, d[0] + 32'h4, 32'h0, 5'd12);
    push_op(regf_pkg::MAIN_MEMORY, regf_pkg::ST_BYTE, 5'd3, 5'd7, 5'd0, 32'h1);
    respond(5'd12, d[7]);
    want_request(regf_pkg::MEM_WRITE, 4'b0001, d[0] + 32'h1, d[4], 5'd0);
    push_op(regf_pkg::MAIN_MEMORY, regf_pkg::ST_HWORD, 5'd3, 5'd7, 5'd0, 32'h2);
    respond(5'd0, 32'h0);
    want_request(regf_pkg::MEM_WRITE, 4'b0011, d[0] + 32'h2, d[4], 5'd0);
    push_op(regf_pkg::MAIN_MEMORY, regf_pkg::ST_WORD, 5'd3, 5'd7, 5'd0, 32'h8);
    respond(5'd0, 32'h0);
    want_request(regf_pkg::MEM_WRITE, 4'b1111, d[0] + 32'h8, d[4], 5'd0);
    push_op(regf_pkg::MAIN_ADDER, regf_pkg::LD_WORD, 5'd10, 5'd11, 5'd0, 32'h0);
    respond(5'd0, 32'h0);
    want_operands(d[5], d[6]);
    push_op(regf_pkg::MAIN_ADDER, regf_pkg::LD_WORD, 5'd12, 5'd0, 5'd0, 32'h0);
    want_operands(d[7], 32'h0);
    // four in flight, the fifth waits for a response
    push_op(regf_pkg::MAIN_MEMORY, regf_pkg::LD_WORD, 5'd0, 5'd0, 5'd13, 32'h100);
    want_request(regf_pkg::MEM_READ, 4'b1111, 32'h100, 32'h0, 5'd13);
    push_op(regf_pkg::MAIN_MEMORY, regf_pkg::LD_WORD, 5'd0, 5'd0, 5'd14, 32'h104);
    want_request(regf_pkg::MEM_READ, 4'b1111, 32'h104, 32'h0, 5'd14);
    push_op(regf_pkg::MAIN_MEMORY, regf_pkg::ST_WORD, 5'd0, 5'd3, 5'd0, 32'h108);
    want_request(regf_pkg::MEM_WRITE, 4'b1111, 32'h108, d[0], 5'd0);
    push_op(regf_pkg::MAIN_MEMORY, regf_pkg::LD_BYTE_UNSIGNED, 5'd0, 5'd0, 5'd15, 32'h10c);
    want_request(regf_pkg::MEM_READ, 4'b0001, 32'h10c, 32'h0, 5'd15);
    push_op(regf_pkg::MAIN_MEMORY, regf_pkg::LD_WORD, 5'd0, 5'd0, 5'd16, 32'h110);
    tbl[n_rows-1].e_stall = 1'b1;
    repeat_op();
    respond(5'd13, d[8]);
    tbl[n_rows-1].e_stall = 1'b1;
    repeat_op();
    want_request(regf_pkg::MEM_READ, 4'b1111, 32'h110, 32'h0, 5'd16);
    push_op(regf_pkg::MAIN_NONE, 8'd0, 5'd0, 5'd0, 5'd0, 32'h0);
    respond(5'd14, d[9]);
    push_op(regf_pkg::MAIN_NONE, 8'd0, 5'd0, 5'd0, 5'd0, 32'h0);
    respond(5'd0, 32'h0);
    push_op(regf_pkg::MAIN_NONE, 8'd0, 5'd0, 5'd0, 5'd0, 32'h0);
    respond(5'd15, d[10]);
    push_op(regf_pkg::MAIN_NONE, 8'd0, 5'd0, 5'd0, 5'd0, 32'h0);
    respond(5'd16, d[11]);
    // load hazard on x5, then back-pressure from memory
    push_op(regf_pkg::MAIN_MEMORY, regf_pkg::LD_WORD, 5'd0, 5'd0, 5'd5, 32'h200);
    want_request(regf_pkg::MEM_READ, 4'b1111, 32'h200, 32'h0, 5'd5);
    push_op(regf_pkg::MAIN_ADDER, regf_pkg::LD_WORD, 5'd5, 5'd0, 5'd0, 32'h0);
    tbl[n_rows-1].e_stall = 1'b1;
    repeat_op();
    tbl[n_rows-1].e_stall = 1'b1;
    repeat_op();
    respond(5'd5, d[12]);
    tbl[n_rows-1].e_stall = 1'b1;
    repeat_op();
    want_operands(d[12], 32'h0);
    push_op(regf_pkg::MAIN_MEMORY, regf_pkg::ST_WORD, 5'd5, 5'd14, 5'd0, 32'h4);
    tbl[n_rows-1].ready   = 1'b0;
    tbl[n_rows-1].e_stall = 1'b1;
    repeat_op();
    tbl[n_rows-1].ready   = 1'b0;
    tbl[n_rows-1].e_stall = 1'b1;
    repeat_op();
    want_request(regf_pkg::MEM_WRITE, 4'b1111, d[12] + 32'h4, d[9], 5'd0);
    push_op(regf_pkg::MAIN_ADDER, regf_pkg::LD_WORD, 5'd15, 5'd16, 5'd0, 32'h0);
    respond(5'd0, 32'h0);
    want_operands(d[10], d[11]);
  endtask

  task automatic apply_row(input row_t r);
    dec_main    <= regf_pkg::main_op_t'(r.main);
    dec_func    <= regf_pkg::func_op_t'(r.func);
    dec_rs1     <= r.rs1;
    dec_rs2     <= r.rs2;
    dec_rd      <= r.rd;
    dec_immd    <= r.immd;
    pc          <= r.pc;
    rob_wr_en   <= r.rob_en;
    rob_wr_addr <= r.rob_addr;
    rob_wr_data <= r.rob_data;
    rsp_vld     <= r.rsp_vld;
    rsp_cid     <= r.rsp_cid;
    rsp_data    <= r.rsp_data;
    req_ready   <= r.ready;
  endtask

  // outputs registered from the row driven one cycle earlier
  task automatic check_registered(input row_t r);
    check("jmp_en", jmp_en, r.e_jmp);
    check("req_valid", req_valid, r.e_req);
    check("isq_rd", isq_rd, r.rd);
    check("isq_func", isq_func, r.func);
    check("isq_immd", isq_immd, r.immd);
    if (r.e_rs_chk) begin
      check("regval_rs1", regval_rs1, r.e_rs1);
      check("regval_rs2", regval_rs2, r.e_rs2);
    end
    if (r.e_req) begin
      check("req_kind", req_kind, r.e_kind);
      check("req_mask", req_mask, r.e_mask);
      check("req_addr", req_addr, r.e_addr);
      check("req_data", req_data, r.e_data);
      check("req_cid", req_cid, r.e_cid);
    end
  endtask

  initial begin
    int total;
    apply_row(blank());
    rstn <= 1'b0;
    build_table();
    table_built = 1'b1;
    repeat (8) @(posedge sclk);
    rstn <= 1'b1;
    for (int k = 0; k <= n_rows; k++) begin
      @(posedge sclk);
      if (k < n_rows) begin
        apply_row(tbl[k]);
      end else begin
        apply_row(blank());
      end
      @(negedge sclk);
      if (k < n_rows) begin
        check("stall", stall, tbl[k].e_stall);
      end
      if (k > 0) begin
        check_registered(tbl[k-1]);
      end
    end
    total = n_errors + dut_i.chk_i.fail_count;
    $display("checks %0d, value errors %0d, assertion failures %0d",
             n_checks, n_errors, dut_i.chk_i.fail_count);
    if (total == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    wait (table_built);
    repeat (n_rows * 10 + 8) @(posedge sclk);  // rows plus reset
    $display("watchdog expired, the table did not finish in time");
    $display(">>> FAIL");
    $finish;
  end

endmodule
